/* hdl/frameReadoutPkg.sv */
`default_nettype none

package frameReadoutPkg;

	////////////////////////////////////////
	// widths and sizes
	////////////////////////////////////////
	localparam int VALUE_W = 24;	// time / calib values
	localparam int COORD_W = 8;		// x and y counters
	localparam int DROP_W = 8;		// saturating drop counter
	localparam int HOST_W = 32;		// host data bus

	localparam int FIFO_DEPTH = 8;	// also the starting credit count
	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CREDIT_W = $clog2(FIFO_DEPTH) + 1;	// must hold FIFO_DEPTH itself

	// fixed word served at the reference endpoint
	localparam logic [HOST_W-1:0] PIPE_REF_WORD = 32'hDEADBEEF;

	// status word layout
	localparam int STATUS_PIPE_READY_BIT = 0;
	localparam int STATUS_TRANSMIT_BIT = 1;
	localparam int STATUS_DROP_LSB = 8;	// dropCount in [15:8]

	////////////////////////////////////////
	// types
	////////////////////////////////////////
	// one captured pixel, 88 bits, y in the top byte
	typedef struct packed {
		logic [COORD_W-1:0] y;
		logic [COORD_W-1:0] x;
		logic [VALUE_W-1:0] timeVal;
		logic [VALUE_W-1:0] calib1;
		logic [VALUE_W-1:0] calib2;
	} pixelSample_t;

	// host endpoint addresses
	typedef enum logic [7:0] {
		EP_PULSEWIDTH = 8'h03,	// the only writable one
		EP_STATUS = 8'h27,
		EP_TIME = 8'h28,
		EP_CALIB1 = 8'h29,
		EP_CALIB2 = 8'h2A,
		EP_HTIME = 8'h2B,
		EP_YCNT = 8'h2C,
		EP_XCNT = 8'h2D,
		EP_PIPE = 8'hA0,		// streaming drain
		EP_REF = 8'hA3
	} hostEndpoint_e;

	// pipe serializer, one state per word of an entry
	typedef enum logic [1:0] {
		WORD_HEADER,
		WORD_TIME,
		WORD_CALIB1,
		WORD_CALIB2
	} pipeWord_e;

endpackage

`default_nettype wire

/* hdl/frameReadoutTop.sv */
`timescale 1ns/1ps
`default_nettype none

module frameReadoutTop (
	input wire logic clk,
	input wire logic reset_n,
	input wire logic transmit,
	input wire logic [frameReadoutPkg::COORD_W-1:0] x,
	input wire logic [frameReadoutPkg::COORD_W-1:0] y,
	input wire logic [frameReadoutPkg::VALUE_W-1:0] timeIn,
	input wire logic [frameReadoutPkg::VALUE_W-1:0] calib1In,
	input wire logic [frameReadoutPkg::VALUE_W-1:0] calib2In,
	input wire logic [frameReadoutPkg::VALUE_W-1:0] hTime,
	input wire frameReadoutPkg::hostEndpoint_e hostAddr,
	input wire logic hostRead,
	input wire logic hostWrite,
	input wire logic [frameReadoutPkg::HOST_W-1:0] hostWriteData,
	output logic [frameReadoutPkg::HOST_W-1:0] hostReadData,
	output logic hostReadValid,
	output logic [frameReadoutPkg::VALUE_W-1:0] pulseWidth
);

	// sampler to fifo
	logic pushValid;
	frameReadoutPkg::pixelSample_t pushSample;
	logic creditReturn;

	// fifo to endpoints
	logic headValid;
	frameReadoutPkg::pixelSample_t headSample;
	logic pop;

	// sampler to endpoints
	frameReadoutPkg::pixelSample_t latestSample;
	logic [frameReadoutPkg::DROP_W-1:0] dropCount;

	////////////////////////////////////////
	// producer, buffer, consumer
	////////////////////////////////////////
	pixelSampler i_sampler (
		.clk(clk), .reset_n(reset_n), .transmit(transmit),
		.x(x), .y(y), .timeIn(timeIn), .calib1In(calib1In), .calib2In(calib2In),
		.creditReturn(creditReturn), .pushValid(pushValid), .pushSample(pushSample),
		.latestSample(latestSample), .dropCount(dropCount)
	);

	sampleFifo i_fifo (
		.clk(clk), .reset_n(reset_n), .pushValid(pushValid), .pushSample(pushSample),
		.pop(pop), .headValid(headValid), .headSample(headSample),
		.creditReturn(creditReturn)
	);

	hostEndpoints i_endpoints (
		.clk(clk), .reset_n(reset_n), .hostAddr(hostAddr), .hostRead(hostRead),
		.hostWrite(hostWrite), .hostWriteData(hostWriteData),
		.latestSample(latestSample), .dropCount(dropCount), .transmit(transmit),
		.hTime(hTime), .headValid(headValid), .headSample(headSample),
		.hostReadData(hostReadData), .hostReadValid(hostReadValid),
		.pulseWidth(pulseWidth), .pop(pop)
	);

endmodule

`default_nettype wire

/* hdl/hostEndpoints.sv */
`timescale 1ns/1ps
`default_nettype none

module hostEndpoints (
	input wire logic clk,
	input wire logic reset_n,
	input wire frameReadoutPkg::hostEndpoint_e hostAddr,
	input wire logic hostRead,
	input wire logic hostWrite,
	input wire logic [frameReadoutPkg::HOST_W-1:0] hostWriteData,
	input wire frameReadoutPkg::pixelSample_t latestSample,
	input wire logic [frameReadoutPkg::DROP_W-1:0] dropCount,
	input wire logic transmit,
	input wire logic [frameReadoutPkg::VALUE_W-1:0] hTime,
	input wire logic headValid,
	input wire frameReadoutPkg::pixelSample_t headSample,
	output logic [frameReadoutPkg::HOST_W-1:0] hostReadData,
	output logic hostReadValid,
	output logic [frameReadoutPkg::VALUE_W-1:0] pulseWidth,
	output logic pop
);

	localparam int HOST_W = frameReadoutPkg::HOST_W;
	localparam int VPAD = HOST_W - frameReadoutPkg::VALUE_W;	// pad for 24-bit values
	localparam int CPAD = HOST_W - frameReadoutPkg::COORD_W;	// pad for one counter
	localparam int HPAD = HOST_W - 2 * frameReadoutPkg::COORD_W;	// header pad

	frameReadoutPkg::pipeWord_e pipeState;
	logic pipeRead;		// pipe read that consumes a word
	logic [HOST_W-1:0] pipeWordData;
	logic [HOST_W-1:0] statusWord;
	logic [HOST_W-1:0] readWord;

	// empty pipe reads return zero and leave the serializer alone
	assign pipeRead = hostRead && (hostAddr == frameReadoutPkg::EP_PIPE) && headValid;
	assign pop = pipeRead && (pipeState == frameReadoutPkg::WORD_CALIB2);	// last word

	////////////////////////////////////////
	// pipe serializer
	////////////////////////////////////////
	always_comb begin
		case (pipeState)
			frameReadoutPkg::WORD_HEADER: pipeWordData = {{HPAD{1'b0}}, headSample.y, headSample.x};
			frameReadoutPkg::WORD_TIME: pipeWordData = {{VPAD{1'b0}}, headSample.timeVal};
			frameReadoutPkg::WORD_CALIB1: pipeWordData = {{VPAD{1'b0}}, headSample.calib1};
			default: pipeWordData = {{VPAD{1'b0}}, headSample.calib2};
		endcase
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			pipeState <= frameReadoutPkg::WORD_HEADER;
		end else if (pipeRead) begin
			case (pipeState)
				frameReadoutPkg::WORD_HEADER: pipeState <= frameReadoutPkg::WORD_TIME;
				frameReadoutPkg::WORD_TIME: pipeState <= frameReadoutPkg::WORD_CALIB1;
				frameReadoutPkg::WORD_CALIB1: pipeState <= frameReadoutPkg::WORD_CALIB2;
				default: pipeState <= frameReadoutPkg::WORD_HEADER;	// entry done
			endcase
		end
	end

	////////////////////////////////////////
	// register endpoints
	////////////////////////////////////////
	always_comb begin
		statusWord = '0;
		statusWord[frameReadoutPkg::STATUS_PIPE_READY_BIT] = headValid;
		statusWord[frameReadoutPkg::STATUS_TRANSMIT_BIT] = transmit;	// live level
		statusWord[frameReadoutPkg::STATUS_DROP_LSB +: frameReadoutPkg::DROP_W] = dropCount;
	end

	// read decode
	always_comb begin
		case (hostAddr)
			frameReadoutPkg::EP_PULSEWIDTH: readWord = {{VPAD{1'b0}}, pulseWidth};
			frameReadoutPkg::EP_STATUS: readWord = statusWord;
			frameReadoutPkg::EP_TIME: readWord = {{VPAD{1'b0}}, latestSample.timeVal};
			frameReadoutPkg::EP_CALIB1: readWord = {{VPAD{1'b0}}, latestSample.calib1};
			frameReadoutPkg::EP_CALIB2: readWord = {{VPAD{1'b0}}, latestSample.calib2};
			frameReadoutPkg::EP_HTIME: readWord = {{VPAD{1'b0}}, hTime};
			frameReadoutPkg::EP_YCNT: readWord = {{CPAD{1'b0}}, latestSample.y};
			frameReadoutPkg::EP_XCNT: readWord = {{CPAD{1'b0}}, latestSample.x};
			frameReadoutPkg::EP_PIPE: readWord = headValid ? pipeWordData : '0;
			frameReadoutPkg::EP_REF: readWord = frameReadoutPkg::PIPE_REF_WORD;
			default: readWord = '0;	// unmapped address
		endcase
	end

	// fixed one-cycle read latency, no stall
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			hostReadValid <= 1'b0;
			hostReadData <= '0;
		end else begin
			hostReadValid <= hostRead;
			if (hostRead)
				hostReadData <= readWord;
		end
	end

	// pulse-width register
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			pulseWidth <= '0;
		else if (hostWrite && (hostAddr == frameReadoutPkg::EP_PULSEWIDTH))
			pulseWidth <= hostWriteData[frameReadoutPkg::VALUE_W-1:0];	// low bits only
	end

endmodule

`default_nettype wire

/* hdl/pixelSampler.sv */
`timescale 1ns/1ps
`default_nettype none

module pixelSampler (
	input wire logic clk,
	input wire logic reset_n,
	input wire logic transmit,
	input wire logic [frameReadoutPkg::COORD_W-1:0] x,
	input wire logic [frameReadoutPkg::COORD_W-1:0] y,
	input wire logic [frameReadoutPkg::VALUE_W-1:0] timeIn,
	input wire logic [frameReadoutPkg::VALUE_W-1:0] calib1In,
	input wire logic [frameReadoutPkg::VALUE_W-1:0] calib2In,
	input wire logic creditReturn,
	output logic pushValid,
	output frameReadoutPkg::pixelSample_t pushSample,
	output frameReadoutPkg::pixelSample_t latestSample,
	output logic [frameReadoutPkg::DROP_W-1:0] dropCount
);

	frameReadoutPkg::pixelSample_t captured;	// assembled from the pixel pins
	logic holdFull;		// pending sample waiting for a credit
	logic slotFree;		// hold register can take a new sample this edge
	logic [frameReadoutPkg::CREDIT_W-1:0] credits;

	// pack the pixel inputs
	assign captured.y = y;
	assign captured.x = x;
	assign captured.timeVal = timeIn;
	assign captured.calib1 = calib1In;
	assign captured.calib2 = calib2In;

	assign pushValid = holdFull && (credits != '0);	// never pushes without a credit
	assign slotFree = !holdFull || pushValid;		// a leaving sample frees the slot

	////////////////////////////////////////
	// credit counter
	////////////////////////////////////////
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			credits <= frameReadoutPkg::CREDIT_W'(frameReadoutPkg::FIFO_DEPTH);
		end else begin
			case ({pushValid, creditReturn})
				2'b10: credits <= credits - 1'b1;	// spend one
				2'b01: credits <= credits + 1'b1;	// fifo freed one
				default: credits <= credits;		// both or neither
			endcase
		end
	end

	////////////////////////////////////////
	// holding register and latest capture
	////////////////////////////////////////
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			holdFull <= 1'b0;
		end else if (transmit && slotFree) begin
			holdFull <= 1'b1;	// refilled even while the old one leaves
		end else if (pushValid) begin
			holdFull <= 1'b0;
		end
	end

	// pending payload
	always_ff @(posedge clk) begin
		if (transmit && slotFree)
			pushSample <= captured;
	end

	// readback copy follows every capture, queued or not
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			latestSample <= '0;
			dropCount <= '0;
		end else if (transmit) begin
			latestSample <= captured;
			if (!slotFree && (dropCount != '1))
				dropCount <= dropCount + 1'b1;	// lost capture, saturates
		end
	end

endmodule

`default_nettype wire

/* hdl/sampleFifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sampleFifo (
	input wire logic clk,
	input wire logic reset_n,
	input wire logic pushValid,
	input wire frameReadoutPkg::pixelSample_t pushSample,
	input wire logic pop,
	output logic headValid,
	output frameReadoutPkg::pixelSample_t headSample,
	output logic creditReturn
);

	localparam int PTR_W = frameReadoutPkg::PTR_W;
	localparam int CNT_W = frameReadoutPkg::CREDIT_W;
	localparam int DEPTH = frameReadoutPkg::FIFO_DEPTH;

	frameReadoutPkg::pixelSample_t mem [DEPTH];	// sample storage, no reset
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;	// occupancy
	logic full;
	logic doPush;
	logic doPop;

	assign full = (count == CNT_W'(DEPTH));
	assign headValid = (count != '0);
	assign headSample = mem[rdPtr];	// show-ahead head

	// credit scheme keeps the producer off a full fifo, guard anyway
	assign doPush = pushValid && !full;
	assign doPop = pop && headValid;

	////////////////////////////////////////
	// storage write
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (doPush)
			mem[wrPtr] <= pushSample;
	end

	////////////////////////////////////////
	// pointers
	////////////////////////////////////////
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			wrPtr <= '0;
		end else if (doPush) begin
			if (wrPtr == PTR_W'(DEPTH - 1))
				wrPtr <= '0;	// wrap
			else
				wrPtr <= wrPtr + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rdPtr <= '0;
		end else if (doPop) begin
			if (rdPtr == PTR_W'(DEPTH - 1))
				rdPtr <= '0;
			else
				rdPtr <= rdPtr + 1'b1;
		end
	end

	// occupancy, simultaneous push and pop cancel out
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			count <= '0;
		end else begin
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////////////////////////
	// credit return
	////////////////////////////////////////
	// one pulse per freed slot, the cycle after the pop
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			creditReturn <= 1'b0;
		else
			creditReturn <= doPop;
	end

endmodule

`default_nettype wire

/* sim.f */
hdl/frameReadoutPkg.sv
hdl/pixelSampler.sv
hdl/sampleFifo.sv
hdl/hostEndpoints.sv
hdl/frameReadoutTop.sv
tb/tbClockGen.sv
tb/frameReadout_props.sv
tb/frameReadoutTb.sv

/* tb/frameReadoutTb.sv */
`timescale 1ns/1ps
`default_nettype none

module frameReadoutTb;

	localparam int STIM_DEPTH = 64;
	localparam int READ_TIMEOUT = 4;	// cycles allowed for read data
	localparam int READY_POLLS = 16;	// status polls before giving up
	localparam logic [23:0] HTIME_VALUE = 24'h3C5A96;

	typedef enum logic [3:0] {
		CMD_END, CMD_CAPTURE, CMD_WRITE, CMD_READ, CMD_IDLE, CMD_DRAIN
	} stimCmd_e;

	// one 100-bit line of the stimulus file
	typedef struct packed {
		stimCmd_e cmd;
		logic [7:0] xAddr;		// x or host address
		logic [7:0] y;
		logic [31:0] value;		// time, data, expected word or cycle count
		logic [23:0] calib1;
		logic [23:0] calib2;
	} stimRecord_t;

	logic clk;
	logic reset_n;
	logic transmit;
	logic [7:0] x;
	logic [7:0] y;
	logic [23:0] timeIn;
	logic [23:0] calib1In;
	logic [23:0] calib2In;
	logic [23:0] hTime;
	frameReadoutPkg::hostEndpoint_e hostAddr;
	logic hostRead;
	logic hostWrite;
	logic [31:0] hostWriteData;
	logic [31:0] hostReadData;
	logic hostReadValid;
	logic [23:0] pulseWidth;

	logic [99:0] stimMem [STIM_DEPTH];
	logic [31:0] lfsrState;
	logic [23:0] expPulse;		// last value written to the pulse-width register
	int errorCount;
	int checkCount;

	tbClockGen i_clockGen (.clk(clk), .reset_n(reset_n));

	frameReadoutTop i_dut (
		.clk(clk), .reset_n(reset_n), .transmit(transmit), .x(x), .y(y),
		.timeIn(timeIn), .calib1In(calib1In), .calib2In(calib2In), .hTime(hTime),
		.hostAddr(hostAddr), .hostRead(hostRead), .hostWrite(hostWrite),
		.hostWriteData(hostWriteData), .hostReadData(hostReadData),
		.hostReadValid(hostReadValid), .pulseWidth(pulseWidth)
	);

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////
	task automatic compareValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// galois form with taps 32 31 29 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
	endfunction

	task automatic randomIdle();
		int n;
		n = 0;
		repeat (2) begin	// one step per bit for 0..3 cycles
			lfsrState = lfsrNext(lfsrState);
			n = (n << 1) | int'(lfsrState[0]);
		end
		repeat (n) @(negedge clk);
	endtask

	task automatic capturePixel(input stimRecord_t rec);
		x = rec.xAddr;
		y = rec.y;
		timeIn = rec.value[23:0];
		calib1In = rec.calib1;
		calib2In = rec.calib2;
		transmit = 1'b1;	// one cycle pulse
		@(negedge clk);
		transmit = 1'b0;
	endtask

	task automatic writeWord(input logic [7:0] addr, input logic [31:0] data);
		hostAddr = frameReadoutPkg::hostEndpoint_e'(addr);
		hostWriteData = data;
		hostWrite = 1'b1;
		@(negedge clk);
		hostWrite = 1'b0;
		if (addr == frameReadoutPkg::EP_PULSEWIDTH)
			expPulse = data[23:0];	// register keeps the low 24 bits
	endtask

	task automatic readWord(input logic [7:0] addr, output logic [31:0] data);
		int waitCycles;
		hostAddr = frameReadoutPkg::hostEndpoint_e'(addr);
		hostRead = 1'b1;
		@(negedge clk);		// sampled by the rising edge just passed
		hostRead = 1'b0;
		waitCycles = 1;
		while (!hostReadValid && waitCycles < READ_TIMEOUT) begin
			@(negedge clk);
			waitCycles++;
		end
		if (!hostReadValid) begin
			errorCount++;
			$display("timeout: no read data from endpoint %h", addr);
		end else begin
			compareValue("hostReadValid latency", waitCycles, 32'd1);
		end
		data = hostReadData;
	endtask

	// poll status for pipe ready then pull the four words of one entry
	task automatic drainEntry(input stimRecord_t rec);
		logic [31:0] data;
		logic [31:0] expWords [4];
		int polls;
		int i;
		expWords[0] = {16'h0, rec.y, rec.xAddr};	// header
		expWords[1] = {8'h0, rec.value[23:0]};
		expWords[2] = {8'h0, rec.calib1};
		expWords[3] = {8'h0, rec.calib2};
		polls = 0;
		data = '0;
		while (!data[0] && polls < READY_POLLS) begin
			readWord(frameReadoutPkg::EP_STATUS, data);
			polls++;
		end
		if (!data[0]) begin
			errorCount++;
			$display("timeout: pipe never became ready");
		end
		for (i = 0; i < 4; i++) begin
			readWord(frameReadoutPkg::EP_PIPE, data);
			compareValue($sformatf("hostReadData pipe word %0d", i), data, expWords[i]);
		end
	endtask

	////////////////////////////////////////
	// stimulus loop
	////////////////////////////////////////
	initial begin
		stimRecord_t rec;
		logic [31:0] data;
		int idx;
		int waits;
		transmit = 1'b0;
		x = '0;
		y = '0;
		timeIn = '0;
		calib1In = '0;
		calib2In = '0;
		hTime = HTIME_VALUE;	// held for the whole run
		hostAddr = frameReadoutPkg::EP_STATUS;
		hostRead = 1'b0;
		hostWrite = 1'b0;
		hostWriteData = '0;
		errorCount = 0;
		checkCount = 0;
		lfsrState = 32'h6e99_6cae;
		expPulse = '0;
		for (idx = 0; idx < STIM_DEPTH; idx++)
			stimMem[idx] = '0;	// unused lines end the run
		$readmemh("tb/frameReadout_stimulus.txt", stimMem);

		waits = 0;
		while (!reset_n && waits < 20) begin
			@(negedge clk);
			waits++;
		end
		if (!reset_n) begin
			errorCount++;
			$display("reset was never released");
		end

		for (idx = 0; idx < STIM_DEPTH; idx++) begin
			rec = stimRecord_t'(stimMem[idx]);
			if (rec.cmd == CMD_END)
				break;
			case (rec.cmd)
				CMD_CAPTURE: capturePixel(rec);
				CMD_IDLE: repeat (rec.value) @(negedge clk);
				CMD_WRITE: begin
					randomIdle();
					writeWord(rec.xAddr, rec.value);
				end
				CMD_READ: begin
					randomIdle();
					readWord(rec.xAddr, data);
					compareValue($sformatf("hostReadData @%h", rec.xAddr), data, rec.value);
				end
				CMD_DRAIN: begin
					randomIdle();
					drainEntry(rec);
				end
				default: begin
					errorCount++;
					$display("unknown command in stimulus line %0d", idx);
				end
			endcase
			compareValue("pulseWidth", {8'h0, pulseWidth}, {8'h0, expPulse});	// reads leave it alone
		end

		// an empty or missing stimulus file runs nothing
		if (idx == 0) begin
			errorCount++;
			$display("no stimulus lines were read from the stimulus file");
		end

		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb/frameReadout_props.sv */
`timescale 1ns/1ps
`default_nettype none

module frameReadout_props (
	input wire logic clk,
	input wire logic reset_n,
	input wire logic hostRead,
	input wire logic hostReadValid,
	input wire logic pushValid,
	input wire logic creditReturn,
	input wire logic pop,
	input wire logic headValid
);

	localparam int CW = frameReadoutPkg::CREDIT_W;

	logic [CW-1:0] creditShadow;	// credits as seen from the handshake
	logic [CW-1:0] fillShadow;		// fifo entries as seen from push and pop

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			creditShadow <= CW'(frameReadoutPkg::FIFO_DEPTH);
			fillShadow <= '0;
		end else begin
			creditShadow <= creditShadow - CW'(pushValid) + CW'(creditReturn);
			fillShadow <= fillShadow + CW'(pushValid) - CW'(pop && headValid);
		end
	end

	////////////////////////////////////////
	// read port timing
	////////////////////////////////////////
	readLatency: assert property (@(posedge clk) disable iff (!reset_n)
		hostRead |=> hostReadValid)
		else $error("read data valid did not follow a read by one cycle");

	noStrayValid: assert property (@(posedge clk) disable iff (!reset_n)
		!hostRead |=> !hostReadValid)
		else $error("read data valid without a read");

	////////////////////////////////////////
	// credits and occupancy
	////////////////////////////////////////
	creditBound: assert property (@(posedge clk) disable iff (!reset_n)
		creditShadow <= CW'(frameReadoutPkg::FIFO_DEPTH))
		else $error("credit count above fifo depth");

	noPushWhenFull: assert property (@(posedge clk) disable iff (!reset_n)
		pushValid |-> (fillShadow != CW'(frameReadoutPkg::FIFO_DEPTH)))
		else $error("push into a full fifo");

endmodule

bind frameReadoutTop frameReadout_props i_props (
	.clk(clk), .reset_n(reset_n), .hostRead(hostRead), .hostReadValid(hostReadValid),
	.pushValid(pushValid), .creditReturn(creditReturn), .pop(pop), .headValid(headValid)
);

`default_nettype wire

/* tb/frameReadout_stimulus.txt */
// cmd_xOrAddr_y_value_calib1_calib2   cmd 1 capture 2 write 3 read 4 idle 5 drain entry
// value is the time, write data, expected read word or idle count
1_12_34_000A1B2C_3D4E5F_607182
3_28_00_000A1B2C_000000_000000
3_29_00_003D4E5F_000000_000000
3_2A_00_00607182_000000_000000
3_2D_00_00000012_000000_000000
3_2C_00_00000034_000000_000000
3_2B_00_003C5A96_000000_000000
3_A3_00_DEADBEEF_000000_000000
3_27_00_00000001_000000_000000
5_12_34_000A1B2C_3D4E5F_607182
2_03_00_A5123456_000000_000000
3_03_00_00123456_000000_000000
1_01_21_00000111_000112_000113
4_00_00_00000005_000000_000000
1_02_21_00000221_000222_000223
4_00_00_00000005_000000_000000
1_03_21_00000331_000332_000333
5_01_21_00000111_000112_000113
5_02_21_00000221_000222_000223
5_03_21_00000331_000332_000333
3_27_00_00000000_000000_000000
3_A0_00_00000000_000000_000000
1_44_55_00ABCDEF_FEDCBA_135790
5_44_55_00ABCDEF_FEDCBA_135790
1_60_70_00100001_200001_300001
1_61_70_00100002_200002_300002
1_62_70_00100003_200003_300003
1_63_70_00100004_200004_300004
1_64_70_00100005_200005_300005
1_65_70_00100006_200006_300006
1_66_70_00100007_200007_300007
1_67_70_00100008_200008_300008
1_68_70_00100009_200009_300009
1_69_70_0010000A_20000A_30000A
3_27_00_00000101_000000_000000
5_60_70_00100001_200001_300001
5_61_70_00100002_200002_300002
5_62_70_00100003_200003_300003
5_63_70_00100004_200004_300004
5_64_70_00100005_200005_300005
5_65_70_00100006_200006_300006
5_66_70_00100007_200007_300007
5_67_70_00100008_200008_300008
5_68_70_00100009_200009_300009
3_28_00_0010000A_000000_000000
3_2D_00_00000069_000000_000000
3_27_00_00000100_000000_000000

/* tb/tbClockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClockGen (
	output logic clk,
	output logic reset_n
);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// reset held for 8 rising edges, released on a falling edge
	initial begin
		reset_n = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
	end

endmodule

`default_nettype wire
